// File: logic/media_defines.svh
// Widths, RAM base addresses and download index codes
// for the media and download controller
`ifndef MEDIA_DEFINES_SVH
`define MEDIA_DEFINES_SVH

// ========================================
// Bus and data widths
// ========================================
`define MEDIA_IOCTL_ADDR_W 27
`define MEDIA_IOCTL_DATA_W 16
`define MEDIA_RAM_DATA_W   32
`define MEDIA_CD_SIZE_W    30
`define MEDIA_IMG_SIZE_W   64
`define MEDIA_INDEX_W      8

// ========================================
// RAM regions for downloaded images
// ========================================
`define MEDIA_BIOS_BASE 27'h0200000
`define MEDIA_EXE_BASE  27'h0400000

// ========================================
// Host download index codes
// ========================================
`define MEDIA_IDX_BIOS 8'd0
`define MEDIA_IDX_EXE  8'd1
// Matched on the low six index bits only
`define MEDIA_IDX_CD   6'd2
`define MEDIA_IDX_SBI  8'd250

`endif

// File: logic/media_pkg.sv
// Shared vector types and packed structs of the media
// and download controller
`default_nettype none

`include "media_defines.svh"

package media_pkg;

	// Plain vectors
	typedef logic [`MEDIA_IOCTL_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [`MEDIA_IOCTL_DATA_W-1:0] ioctl_data_t;
	typedef logic [`MEDIA_RAM_DATA_W-1:0]   ram_word_t;
	typedef logic [`MEDIA_CD_SIZE_W-1:0]    cd_size_t;
	typedef logic [`MEDIA_IMG_SIZE_W-1:0]   img_size_t;

	// Host download bus, 53 bits
	typedef struct packed {
		logic                     download;
		logic [`MEDIA_INDEX_W-1:0] index;
		ioctl_addr_t              addr;
		ioctl_data_t              dout;
		logic                     wr;
	} ioctl_bus_t;

	// Registered download kind
	typedef struct packed {
		logic bios;
		logic exe;
		logic cd;
		logic sbi;
	} dl_flags_t;

	// Packed RAM write request
	typedef struct packed {
		logic        wr;
		ioctl_addr_t addr;
		ram_word_t   data;
	} ram_write_t;

	// Slot 1 is the CD, slots 2 and 3 the memory cards
	typedef struct packed {
		logic [3:0] mounted;
		img_size_t  size;
	} img_mount_t;

	typedef struct packed {
		logic load_req;
		logic save_req;
		logic autosave;
		logic osd_open;
	} memcard_opt_t;

	typedef struct packed {
		logic load1;
		logic load2;
		logic save;
	} memcard_cmd_t;

endpackage

`default_nettype wire

// File: logic/download_decoder.sv
// Download kind decode, core reset, executable start pulse
// and libcrypt key capture
`timescale 1ns/1ps
`default_nettype none

`include "media_defines.svh"

module download_decoder
	import media_pkg::*;
(
	input  wire        clk_1x,
	input  wire        reset,
	input  wire ioctl_bus_t ioctl,
	output dl_flags_t  flags,
	output logic       core_reset,
	output logic       exe_start,
	output ioctl_data_t libcrypt_key
);

	// Exe flag of the previous cycle, for the falling edge
	logic exe_q;

	// ========================================
	// Download kind flags
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			flags     <= '0;
			exe_q     <= 1'b0;
			exe_start <= 1'b0;
		end else begin
			flags.bios <= ioctl.download && (ioctl.index == `MEDIA_IDX_BIOS);
			flags.exe  <= ioctl.download && (ioctl.index == `MEDIA_IDX_EXE);
			flags.cd   <= ioctl.download && (ioctl.index[5:0] == `MEDIA_IDX_CD);
			flags.sbi  <= ioctl.download && (ioctl.index == `MEDIA_IDX_SBI);
			exe_q      <= flags.exe;
			// One pulse once the executable is in RAM
			exe_start  <= exe_q && !flags.exe;
		end
	end

	// Core stays in reset while an image is loading
	assign core_reset = reset | flags.bios | flags.exe | flags.cd;

	// ========================================
	// Libcrypt key
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (flags.sbi && ioctl.wr) begin
			libcrypt_key <= ioctl.dout;
		end
	end

endmodule

`default_nettype wire

// File: logic/ram_loader.sv
// Packs host words into 32-bit RAM writes at the BIOS or
// executable base and stalls the host until the acknowledge
`timescale 1ns/1ps
`default_nettype none

`include "media_defines.svh"

module ram_loader
	import media_pkg::*;
(
	input  wire        clk_1x,
	input  wire        reset,
	input  wire ioctl_bus_t ioctl,
	input  wire dl_flags_t  flags,
	output ram_write_t ram_wr,
	input  wire        ram_ack,
	output logic       ioctl_wait
);

	logic        wr_q;
	ioctl_addr_t addr_q;
	ram_word_t   data_q;
	ioctl_addr_t region_base;
	logic        ram_dl;
	logic        low_half;
	logic        high_half;

	// Only BIOS and executable images go to RAM
	assign ram_dl = flags.bios | flags.exe;

	assign region_base = flags.bios ? `MEDIA_BIOS_BASE : `MEDIA_EXE_BASE;

	// Address bit 1 selects the half of the RAM word
	assign low_half  = ram_dl && ioctl.wr && !ioctl.addr[1];
	assign high_half = ram_dl && ioctl.wr && ioctl.addr[1];

	// ========================================
	// Write request and host wait
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			wr_q       <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			wr_q <= 1'b0;
			if (ram_dl) begin
				if (high_half) begin
					wr_q       <= 1'b1;
					ioctl_wait <= 1'b1;
				end
				// Host may continue once the memory took the word
				if (ram_ack) begin
					ioctl_wait <= 1'b0;
				end
			end else begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// ========================================
	// Address and data assembly
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (low_half) begin
			data_q[15:0] <= ioctl.dout;
			addr_q       <= ioctl.addr + region_base;
		end
		if (high_half) begin
			data_q[31:16] <= ioctl.dout;
		end
	end

	// Address and data hold until the next write
	assign ram_wr = '{wr: wr_q, addr: addr_q, data: data_q};

endmodule

`default_nettype wire

// File: logic/cd_image_tracker.sv
// CD image size, presence and source, from a download or an SD mount
`timescale 1ns/1ps
`default_nettype none

`include "media_defines.svh"

module cd_image_tracker
	import media_pkg::*;
(
	input  wire        clk_1x,
	input  wire        reset,
	input  wire ioctl_bus_t ioctl,
	input  wire dl_flags_t  flags,
	input  wire img_mount_t mount,
	output cd_size_t   cd_size,
	output logic       has_cd,
	output logic       cd_from_sd
);

	logic cd_q;
	logic dl_done;
	logic mount_cd;
	logic size_nz;

	// End of a CD download, seen on the falling cd flag
	assign dl_done  = cd_q && !flags.cd;
	assign mount_cd = mount.mounted[1];
	assign size_nz  = |mount.size;

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			cd_q       <= 1'b0;
			has_cd     <= 1'b0;
			cd_from_sd <= 1'b0;
		end else begin
			cd_q <= flags.cd;
			// Mount takes priority over a finished download
			if (mount_cd) begin
				has_cd <= size_nz;
			end else if (dl_done) begin
				has_cd <= 1'b1;
			end
			if (mount_cd && size_nz) begin
				cd_from_sd <= 1'b1;
			end else if (dl_done) begin
				cd_from_sd <= 1'b0;
			end
		end
	end

	// Size of the image, last download address or mount size
	always_ff @(posedge clk_1x) begin
		if (mount_cd && size_nz) begin
			cd_size <= mount.size[`MEDIA_CD_SIZE_W-1:0];
		end else if (dl_done) begin
			cd_size <= cd_size_t'(ioctl.addr);
		end
	end

endmodule

`default_nettype wire

// File: logic/memcard_ctrl.sv
// Memory card mount state and load/save pulse generation
`timescale 1ns/1ps
`default_nettype none

module memcard_ctrl
	import media_pkg::*;
(
	input  wire          clk_1x,
	input  wire          reset,
	input  wire img_mount_t   mount,
	input  wire memcard_opt_t opt,
	output logic         card1_present,
	output logic         card2_present,
	output memcard_cmd_t cmd
);

	logic size_nz;
	logic mount1;
	logic mount2;
	logic save_auto;

	// Previous cycle values for edge detection
	logic load_q;
	logic save_q;
	logic save_auto_q;

	logic load_rise;
	logic save_rise;

	assign size_nz = |mount.size;

	// Slot 2 is card 1, slot 3 is card 2
	assign mount1 = mount.mounted[2];
	assign mount2 = mount.mounted[3];

	// Autosave only fires while the menu is open
	assign save_auto = opt.autosave & opt.osd_open;

	assign load_rise = opt.load_req && !load_q;
	assign save_rise = (opt.save_req && !save_q) || (save_auto && !save_auto_q);

	// ========================================
	// Presence and pulses
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			card1_present <= 1'b0;
			card2_present <= 1'b0;
			cmd           <= '0;
			load_q        <= 1'b0;
			save_q        <= 1'b0;
			save_auto_q   <= 1'b0;
		end else begin
			load_q      <= opt.load_req;
			save_q      <= opt.save_req;
			save_auto_q <= save_auto;

			if (mount1) begin
				card1_present <= size_nz;
			end
			if (mount2) begin
				card2_present <= size_nz;
			end

			// Each pulse lasts a single cycle
			cmd.load1 <= (mount1 && size_nz) || load_rise;
			cmd.load2 <= (mount2 && size_nz) || load_rise;
			cmd.save  <= save_rise;
		end
	end

endmodule

`default_nettype wire

// File: logic/media_ctrl_top.sv
// Top level of the media and download controller
`timescale 1ns/1ps
`default_nettype none

module media_ctrl_top
	import media_pkg::*;
(
	input  wire          clk_1x,
	input  wire          reset,
	input  wire ioctl_bus_t   ioctl,
	input  wire img_mount_t   mount,
	input  wire memcard_opt_t opt,
	input  wire          ram_ack,
	output ram_write_t   ram_wr,
	output logic         ioctl_wait,
	output logic         core_reset,
	output logic         exe_start,
	output ioctl_data_t  libcrypt_key,
	output cd_size_t     cd_size,
	output logic         has_cd,
	output logic         cd_from_sd,
	output logic         card1_present,
	output logic         card2_present,
	output memcard_cmd_t cmd
);

	// Registered download kind, shared by loader and CD tracker
	dl_flags_t flags;

	// ========================================
	// Download decode
	// ========================================
	download_decoder u_download_decoder (
		.clk_1x       (clk_1x),
		.reset        (reset),
		.ioctl        (ioctl),
		.flags        (flags),
		.core_reset   (core_reset),
		.exe_start    (exe_start),
		.libcrypt_key (libcrypt_key)
	);

	// RAM write path
	ram_loader u_ram_loader (
		.clk_1x     (clk_1x),
		.reset      (reset),
		.ioctl      (ioctl),
		.flags      (flags),
		.ram_wr     (ram_wr),
		.ram_ack    (ram_ack),
		.ioctl_wait (ioctl_wait)
	);

	// ========================================
	// Media state
	// ========================================
	cd_image_tracker u_cd_image_tracker (
		.clk_1x     (clk_1x),
		.reset      (reset),
		.ioctl      (ioctl),
		.flags      (flags),
		.mount      (mount),
		.cd_size    (cd_size),
		.has_cd     (has_cd),
		.cd_from_sd (cd_from_sd)
	);

	memcard_ctrl u_memcard_ctrl (
		.clk_1x        (clk_1x),
		.reset         (reset),
		.mount         (mount),
		.opt           (opt),
		.card1_present (card1_present),
		.card2_present (card2_present),
		.cmd           (cmd)
	);

endmodule

`default_nettype wire

// File: bench/media_ctrl_asserts.sv
// Concurrent assertions on the RAM write handshake and host wait,
// bound to the RAM loader
`timescale 1ns/1ps
`default_nettype none

module media_ctrl_asserts
	import media_pkg::*;
(
	input wire             clk_1x,
	input wire             reset,
	input wire dl_flags_t  flags,
	input wire ram_write_t ram_wr,
	input wire             ram_ack,
	input wire             ioctl_wait
);

	int fail_count = 0;

	// Write request is a single-cycle pulse
	wr_one_cycle: assert property (@(posedge clk_1x) disable iff (reset)
		ram_wr.wr |=> !ram_wr.wr)
		else begin
			$error("ram wr held high for more than one cycle");
			fail_count++;
		end

	// Wait drops on an acknowledge, or when the RAM download is gone
	wait_after_ack: assert property (@(posedge clk_1x) disable iff (reset)
		$fell(ioctl_wait) |-> $past(ram_ack) || !$past(flags.bios || flags.exe))
		else begin
			$error("ioctl_wait fell without a ram_ack");
			fail_count++;
		end

	wait_only_in_ram_dl: assert property (@(posedge clk_1x) disable iff (reset)
		!(flags.bios || flags.exe) |=> !ioctl_wait)
		else begin
			$error("ioctl_wait high outside a BIOS or executable download");
			fail_count++;
		end

endmodule

bind ram_loader media_ctrl_asserts u_asserts (
	.clk_1x     (clk_1x),
	.reset      (reset),
	.flags      (flags),
	.ram_wr     (ram_wr),
	.ram_ack    (ram_ack),
	.ioctl_wait (ioctl_wait)
);

`default_nettype wire

// File: bench/media_ctrl_tb.sv
// Media and download controller testbench with memory responder,
// LFSR stimulus, directed tests and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "media_defines.svh"

module media_ctrl_tb
	import media_pkg::*;
();

	localparam int CLK_PERIOD    = 4;
	localparam int RESET_CYCLES  = 16;
	localparam int MAX_ACK_DELAY = 7;
	localparam int BIOS_PAIRS    = 6;
	localparam int EXE_PAIRS     = 6;
	// Worst case per word pair plus the tests without RAM traffic
	localparam int WATCHDOG_CYCLES = RESET_CYCLES
		+ (BIOS_PAIRS + EXE_PAIRS) * (MAX_ACK_DELAY + 6) + 400;

	logic         clk_1x;
	logic         reset;
	ioctl_bus_t   ioctl;
	img_mount_t   mount;
	memcard_opt_t opt;
	logic         ram_ack;
	ram_write_t   ram_wr;
	logic         ioctl_wait;
	logic         core_reset;
	logic         exe_start;
	ioctl_data_t  libcrypt_key;
	cd_size_t     cd_size;
	logic         has_cd;
	logic         cd_from_sd;
	logic         card1_present;
	logic         card2_present;
	memcard_cmd_t cmd;

	int          errors;
	int          checks;
	logic [15:0] lfsr;
	ioctl_addr_t wr_addr_q[$];
	ram_word_t   wr_data_q[$];

	media_ctrl_top dut (.*);

	initial begin
		clk_1x = 1'b0;
		forever #(CLK_PERIOD / 2) clk_1x = ~clk_1x;
	end

	// ========================================
	// Helpers
	// ========================================
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[14:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_1x);
		#1;
	endtask

	task automatic wait_host_ready();
		int n;
		n = 0;
		while (ioctl_wait && n < MAX_ACK_DELAY + 4) begin
			next_cycle();
			n++;
		end
		if (ioctl_wait) begin
			errors++;
			$display("ioctl_wait stayed high, no acknowledge ended the write");
		end
	endtask

	task automatic send_word(input ioctl_addr_t addr, input ioctl_data_t data);
		ioctl.addr = addr;
		ioctl.dout = data;
		ioctl.wr   = 1'b1;
		next_cycle();
		ioctl.wr = 1'b0;
		wait_host_ready();
	endtask

	task automatic start_download(input logic [7:0] index);
		ioctl.download = 1'b1;
		ioctl.index    = index;
		repeat (2) next_cycle();
	endtask

	task automatic end_download();
		ioctl.download = 1'b0;
		next_cycle();
	endtask

	task automatic mount_image(input logic [3:0] slots, input img_size_t size);
		mount.mounted = slots;
		mount.size    = size;
		next_cycle();
		mount = '0;
	endtask

	task automatic count_pulses(input int cycles, output int n1, output int n2,
		output int ns);
		n1 = 0;
		n2 = 0;
		ns = 0;
		repeat (cycles) begin
			n1 += cmd.load1;
			n2 += cmd.load2;
			ns += cmd.save;
			next_cycle();
		end
	endtask

	// Memory side acknowledges each write after 0 to 7 cycles
	initial begin : responder
		logic [15:0] delay;
		ram_ack = 1'b0;
		forever begin
			next_cycle();
			if (ram_wr.wr) begin
				wr_addr_q.push_back(ram_wr.addr);
				wr_data_q.push_back(ram_wr.data);
				take_bits(3, delay);
				repeat (delay[2:0]) next_cycle();
				ram_ack = 1'b1;
				next_cycle();
				ram_ack = 1'b0;
			end
		end
	end

	// ========================================
	// Directed tests
	// ========================================
	task automatic ram_download(input logic [7:0] index, input ioctl_addr_t base,
		input int pairs);
		logic [15:0] lo;
		logic [15:0] hi;
		ioctl_addr_t a;
		start_download(index);
		for (int p = 0; p < pairs; p++) begin
			a = ioctl_addr_t'(p * 4);
			take_bits(16, lo);
			take_bits(16, hi);
			send_word(a, lo);
			send_word(a + 2, hi);
			check_value("ram write count", wr_addr_q.size(), 1);
			if (wr_addr_q.size() > 0) begin
				check_value("ram_wr.addr", wr_addr_q[0], a + base);
				check_value("ram_wr.data", wr_data_q[0], {hi, lo});
			end
			wr_addr_q.delete();
			wr_data_q.delete();
			check_value("ioctl_wait", ioctl_wait, 0);
			check_value("core_reset", core_reset, 1);
		end
		end_download();
	endtask

	task automatic cd_download(input logic [7:0] index, input int words);
		logic [15:0] d;
		start_download(index);
		for (int i = 0; i < words; i++) begin
			take_bits(16, d);
			send_word(ioctl_addr_t'(i * 2), d);
			check_value("core_reset", core_reset, 1);
		end
		end_download();
		repeat (2) next_cycle();
	endtask

	task automatic bios_download();
		ram_download(`MEDIA_IDX_BIOS, `MEDIA_BIOS_BASE, BIOS_PAIRS);
		repeat (2) next_cycle();
		check_value("core_reset", core_reset, 0);
	endtask

	task automatic exe_download();
		int starts;
		ram_download(`MEDIA_IDX_EXE, `MEDIA_EXE_BASE, EXE_PAIRS);
		starts = 0;
		repeat (8) begin
			starts += exe_start;
			next_cycle();
		end
		check_value("exe_start cycles", starts, 1);
		check_value("core_reset", core_reset, 0);
	endtask

	task automatic cd_download_and_mount();
		img_size_t size;
		// Upper index bits are ignored for the CD code
		cd_download(8'h42, 6);
		check_value("cd_size", cd_size, 10);
		check_value("has_cd", has_cd, 1);
		check_value("cd_from_sd", cd_from_sd, 0);
		check_value("ram write count", wr_addr_q.size(), 0);
		size = 64'h0000_00a5_1234_5678;
		mount_image(4'b0010, size);
		check_value("cd_size", cd_size, size[29:0]);
		check_value("has_cd", has_cd, 1);
		check_value("cd_from_sd", cd_from_sd, 1);
		mount_image(4'b0010, '0);
		check_value("has_cd", has_cd, 0);
		// A new download replaces the SD image
		cd_download(8'h02, 4);
		check_value("cd_size", cd_size, 6);
		check_value("has_cd", has_cd, 1);
		check_value("cd_from_sd", cd_from_sd, 0);
	endtask

	task automatic memcard_events();
		int n1;
		int n2;
		int ns;
		mount_image(4'b0100, 64'h20000);
		count_pulses(6, n1, n2, ns);
		check_value("card1_present", card1_present, 1);
		check_value("cmd.load1 pulses", n1, 1);
		check_value("cmd.load2 pulses", n2, 0);
		mount_image(4'b1000, 64'h20000);
		count_pulses(6, n1, n2, ns);
		check_value("card2_present", card2_present, 1);
		check_value("cmd.load2 pulses", n2, 1);
		mount_image(4'b0100, '0);
		count_pulses(6, n1, n2, ns);
		check_value("card1_present", card1_present, 0);
		check_value("cmd.load1 pulses", n1, 0);
		check_value("card2_present", card2_present, 1);
		opt.load_req = 1'b1;
		count_pulses(6, n1, n2, ns);
		check_value("cmd.load1 pulses", n1, 1);
		check_value("cmd.load2 pulses", n2, 1);
		check_value("cmd.save pulses", ns, 0);
		opt.load_req = 1'b0;
		opt.save_req = 1'b1;
		count_pulses(6, n1, n2, ns);
		check_value("cmd.save pulses", ns, 1);
		opt.save_req = 1'b0;
		// Autosave with the menu closed does nothing
		opt.autosave = 1'b1;
		count_pulses(6, n1, n2, ns);
		check_value("cmd.save pulses", ns, 0);
		opt.osd_open = 1'b1;
		count_pulses(6, n1, n2, ns);
		check_value("cmd.save pulses", ns, 1);
		opt = '0;
		next_cycle();
	endtask

	task automatic libcrypt_capture();
		logic [15:0] key;
		start_download(`MEDIA_IDX_SBI);
		take_bits(16, key);
		send_word('0, key);
		check_value("core_reset", core_reset, 0);
		end_download();
		repeat (2) next_cycle();
		check_value("libcrypt_key", libcrypt_key, key);
		check_value("ioctl_wait", ioctl_wait, 0);
		check_value("ram write count", wr_addr_q.size(), 0);
	endtask

	// ========================================
	// Main sequence and watchdog
	// ========================================
	initial begin
		int afails;
		errors = 0;
		checks = 0;
		lfsr   = 16'd25275;
		reset  = 1'b1;
		ioctl  = '0;
		mount  = '0;
		opt    = '0;
		repeat (RESET_CYCLES) next_cycle();
		reset = 1'b0;
		next_cycle();
		check_value("ram_wr.wr", ram_wr.wr, 0);
		check_value("ioctl_wait", ioctl_wait, 0);
		check_value("exe_start", exe_start, 0);
		check_value("cmd", cmd, 0);
		check_value("has_cd", has_cd, 0);
		check_value("card1_present", card1_present, 0);
		check_value("card2_present", card2_present, 0);
		bios_download();
		exe_download();
		cd_download_and_mount();
		memcard_events();
		libcrypt_capture();
		afails = dut.u_ram_loader.u_asserts.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, afails);
		if (errors + afails == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/media_pkg.sv
logic/download_decoder.sv
logic/ram_loader.sv
logic/cd_image_tracker.sv
logic/memcard_ctrl.sv
logic/media_ctrl_top.sv
bench/media_ctrl_asserts.sv
bench/media_ctrl_tb.sv

// File: Bender.yml
package:
  name: media_ctrl

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/media_pkg.sv
      - logic/download_decoder.sv
      - logic/ram_loader.sv
      - logic/cd_image_tracker.sv
      - logic/memcard_ctrl.sv
      - logic/media_ctrl_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/media_ctrl_asserts.sv
      - bench/media_ctrl_tb.sv
